/* videoDma.f */
hw/videoDmaPkg.sv
hw/ufiBusIf.sv
hw/dmaWriteFifo.sv
hw/videoDmaUnit.sv
hw/frameBufferRam.sv
hw/videoDmaTop.sv
verification/videoDmaChk.sv
verification/videoDmaTb.sv

/* run.sh */
#!/bin/sh
# Build the video DMA testbench with Verilator, run it, look for the pass line

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module videoDmaTb -f videoDma.f -o videoDmaSim \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/videoDmaSim | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

/* verification/videoDmaTb.sv */
// Video DMA subsystem testbench
`default_nettype none

module videoDmaTb
	import videoDmaPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int frameLen = 64;      // Words per region

	logic                     iClk = 1'b0;
	logic                     rst;
	logic [cUfiBusWidth-1:0]  pixWd;
	logic                     pixWe;
	wire                      pixFull;
	wire  [cUfiBusWidth-1:0]  pixRd;
	wire                      pixREd;
	logic                     pixRe;
	logic [cMemAdrsWidth-1:0] fbufAdrs1;
	logic [cMemAdrsWidth-1:0] fbufAdrs2;
	logic [cMemAdrsWidth-1:0] fbufLen1;
	logic [cMemAdrsWidth-1:0] fbufLen2;
	logic                     dmaEn;

	// Frame model
	logic [cUfiBusWidth-1:0] wrQ [$];   // Pushed pixels awaiting readback
	logic [cUfiBusWidth-1:0] nextPix;
	int srcTarget;                      // Pixels to push this session
	int pushCount;
	int readIdx;                        // Sink words this session
	int garbageCnt;                     // Frame 0 words left unchecked
	int sinceRe;                        // Cycles since pixRe was high
	int reLeft;
	bit reOn;
	bit sinkOn;
	int cycle;
	int dataErrs;
	int protoErrs;
	int timeoutErrs;

	always #2 iClk = ~iClk;   // 4 ns period

	videoDmaTop #(
		.pUfiBusWidth(cUfiBusWidth), .pMemAdrsWidth(cMemAdrsWidth), .pFifoDepth(cFifoDepth)
	) uut (
		.iClk(iClk), .rst(rst),
		.pixWd(pixWd), .pixWe(pixWe), .pixFull(pixFull),
		.pixRd(pixRd), .pixREd(pixREd), .pixRe(pixRe),
		.fbufAdrs1(fbufAdrs1), .fbufAdrs2(fbufAdrs2),
		.fbufLen1(fbufLen1), .fbufLen2(fbufLen2), .dmaEn(dmaEn)
	);

	// ------------------------------------------------------------
	// Per-cycle sampling and stimulus
	// ------------------------------------------------------------
	task automatic checkOutputs();
		logic [cUfiBusWidth-1:0] expPix;
		if (cycle >= 2 && cycle <= 12)         // In reset and just out of it
		begin
			assert (pixREd === 1'b0)
			else
			begin
				protoErrs++;
				$display("mismatch at %0d ns: pixREd expected 0, got %b", $time, pixREd);
			end
			assert (pixFull === 1'b0)
			else
			begin
				protoErrs++;
				$display("mismatch at %0d ns: pixFull expected 0, got %b", $time, pixFull);
			end
		end
		if (pixREd)
		begin
			assert (sinceRe <= 2)
			else
			begin
				protoErrs++;
				$display("Read data at %0d ns, %0d cycles after pixRe fell", $time, sinceRe + 1);
			end
			// Read frame k needs written frame k-1 complete
			assert (readIdx / frameLen <= pushCount / frameLen)
			else
			begin
				protoErrs++;
				$display("Read frame %0d began before its source frame was written",
					readIdx / frameLen);
			end
			if (readIdx < frameLen)
				garbageCnt++;
			else if (wrQ.size() == 0)
			begin
				protoErrs++;
				$display("Read word %0d at %0d ns has no written pixel to match", readIdx, $time);
			end
			else
			begin
				expPix = wrQ.pop_front();
				assert (pixRd == expPix)
				else
				begin
					dataErrs++;
					$display("mismatch at %0d ns: pixRd expected %h, got %h", $time, expPix, pixRd);
				end
			end
			readIdx++;
		end
		if (pixRe)
			sinceRe = 0;
		else if (sinceRe < 1000)
			sinceRe++;
	endtask

	task automatic driveSource();
		if (pixWe)
			pixWe <= 1'b0;                   // One push every other cycle at most
		else if (pushCount < srcTarget && !pixFull && $urandom_range(3) != 0)
		begin
			pixWe <= 1'b1;
			pixWd <= nextPix;
			wrQ.push_back(nextPix);
			pushCount++;
			nextPix = nextPix + cUfiBusWidth'(1 + $urandom_range(6));
		end
	endtask

	task automatic driveSink();
		if (!sinkOn)
		begin
			pixRe <= 1'b0;
			reLeft = 0;
		end
		else
		begin
			if (reLeft == 0)
			begin
				reOn = ($urandom_range(2) != 0);      // Bursts favoured over gaps
				reLeft = 1 + int'($urandom_range(15));
			end
			pixRe <= reOn;
			reLeft--;
		end
	endtask

	task automatic stepCycle();
		@(posedge iClk);
		cycle++;
		checkOutputs();
		driveSource();
		driveSink();
	endtask

	// ------------------------------------------------------------
	// Bounded waits
	// ------------------------------------------------------------
	task automatic waitReads(input int target, input int limit);
		int waited;
		waited = 0;
		while (readIdx < target && waited < limit)
		begin
			stepCycle();
			waited++;
		end
		assert (readIdx >= target)
		else
		begin
			timeoutErrs++;
			$display("Timed out waiting for read data, %0d of %0d words seen", readIdx, target);
		end
	endtask

	task automatic waitFull(input logic level, input int limit);
		int waited;
		waited = 0;
		while (pixFull !== level && waited < limit)
		begin
			stepCycle();
			waited++;
		end
		assert (pixFull === level)
		else
		begin
			timeoutErrs++;
			$display("Timed out waiting for pixFull to become %b", level);
		end
	endtask

	// Reader must stay parked at its region end
	task automatic checkSettled(input int reads);
		repeat (40) stepCycle();
		assert (readIdx == reads && pushCount == srcTarget && wrQ.size() == 0)
		else
		begin
			protoErrs++;
			$display("Frame count off: %0d words read, %0d expected, %0d pixels unread",
				readIdx, reads, wrQ.size());
		end
	endtask

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------
	initial
	begin
		int seedVal;
		seedVal = $urandom(32'h3b24_0b9c);
		rst = 1'b1;
		pixWd = '0;
		pixWe = 1'b0;
		pixRe = 1'b0;
		dmaEn = 1'b0;
		fbufAdrs1 = cMemAdrsWidth'(0);
		fbufAdrs2 = cMemAdrsWidth'(256);
		fbufLen1 = cMemAdrsWidth'(frameLen);
		fbufLen2 = cMemAdrsWidth'(frameLen);
		nextPix = '0;
		srcTarget = 0;
		pushCount = 0;
		readIdx = 0;
		garbageCnt = 0;
		sinceRe = 1000;
		reLeft = 0;
		reOn = 1'b0;
		sinkOn = 1'b0;
		cycle = 0;
		dataErrs = 0;
		protoErrs = 0;
		timeoutErrs = 0;

		repeat (10) stepCycle();
		rst <= 1'b0;
		repeat (3) stepCycle();
		dmaEn <= 1'b1;

		// Four frames with a random sink
		sinkOn = 1'b1;
		srcTarget = 4 * frameLen;
		waitReads(5 * frameLen, 20000);
		checkSettled(5 * frameLen);

		// Sink stalled until the FIFO backs up
		sinkOn = 1'b0;
		srcTarget = 7 * frameLen;
		waitFull(1'b1, 5000);
		repeat (20) stepCycle();
		sinkOn = 1'b1;
		waitFull(1'b0, 2000);
		waitReads(8 * frameLen, 20000);
		checkSettled(8 * frameLen);

		// Disable while idle, then start over at region 1
		dmaEn <= 1'b0;
		repeat (5) stepCycle();
		wrQ.delete();
		readIdx = 0;
		pushCount = 0;
		srcTarget = 3 * frameLen;
		dmaEn <= 1'b1;
		waitReads(4 * frameLen, 20000);
		checkSettled(4 * frameLen);

		$display("Unchecked frame 0 words %0d, errors: data %0d, protocol %0d, timeout %0d",
			garbageCnt, dataErrs, protoErrs, timeoutErrs);
		if (dataErrs + protoErrs + timeoutErrs == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/videoDmaChk.sv */
// DMA engine bus and strobe checker
`default_nettype none

module videoDmaChk
	import videoDmaPkg::*;
#(
	parameter int pAdrsWidth = cMemAdrsWidth
)(
	input wire                  iClk,
	input wire                  rst,
	input wire                  adrsSel,
	input wire                  wEd,
	input wire                  rEd,
	input wire                  rdy,
	input wire [pAdrsWidth-1:0] adrs,
	input wire                  pixREd,
	input wire [pAdrsWidth-1:0] fbufAdrs1,
	input wire [pAdrsWidth-1:0] fbufAdrs2,
	input wire [pAdrsWidth-1:0] fbufLen1,
	input wire [pAdrsWidth-1:0] fbufLen2
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [pAdrsWidth-1:0] wrBase;
	logic [pAdrsWidth-1:0] wrEnd;
	logic [pAdrsWidth-1:0] rdBase;
	logic [pAdrsWidth-1:0] rdEnd;

	// Roles follow the region select, writer and reader opposite
	assign wrBase = adrsSel ? fbufAdrs2 : fbufAdrs1;
	assign wrEnd  = adrsSel ? fbufAdrs2 + fbufLen2 : fbufAdrs1 + fbufLen1;
	assign rdBase = adrsSel ? fbufAdrs1 : fbufAdrs2;
	assign rdEnd  = adrsSel ? fbufAdrs1 + fbufLen1 : fbufAdrs2 + fbufLen2;

	// ------------------------------------------------------------
	// Bus protocol
	// ------------------------------------------------------------
	aOneStrobe: assert property (@(posedge iClk) disable iff (rst) !(wEd && rEd))
		else $error("Write and read strobes high in the same cycle");

	aRdyBefore: assert property (@(posedge iClk) disable iff (rst) (wEd || rEd) |-> $past(rdy))
		else $error("Strobe issued after a cycle with ready low");

	aReadPipe: assert property (@(posedge iClk) disable iff (rst) pixREd |-> $past(rEd, 2))
		else $error("Sink strobe without a read two cycles earlier");

	// Address inside the region of its role
	aWrRegion: assert property (@(posedge iClk) disable iff (rst)
		wEd |-> (adrs >= wrBase && adrs < wrEnd))
		else $error("Write address outside the writer region");

	aRdRegion: assert property (@(posedge iClk) disable iff (rst)
		rEd |-> (adrs >= rdBase && adrs < rdEnd))
		else $error("Read address outside the reader region");

endmodule

bind videoDmaUnit videoDmaChk #(.pAdrsWidth(pMemAdrsWidth)) dmaChk (
	.iClk(iClk), .rst(rst), .adrsSel(adrsSel),
	.wEd(bus.wEd), .rEd(bus.rEd), .rdy(bus.rdy), .adrs(bus.adrs),
	.pixREd(pixREd),
	.fbufAdrs1(fbufAdrs1), .fbufAdrs2(fbufAdrs2),
	.fbufLen1(fbufLen1), .fbufLen2(fbufLen2)
);

`default_nettype wire

/* hw/videoDmaTop.sv */
// Video DMA subsystem top
`default_nettype none

module videoDmaTop
	import videoDmaPkg::*;
#(
	parameter int pUfiBusWidth  = cUfiBusWidth,
	parameter int pMemAdrsWidth = cMemAdrsWidth,
	parameter int pFifoDepth    = cFifoDepth
)(
	input  wire                      iClk,
	input  wire                      rst,
	// Pixel source
	input  wire  [pUfiBusWidth-1:0]  pixWd,
	input  wire                      pixWe,
	output wire                      pixFull,
	// Pixel sink
	output wire  [pUfiBusWidth-1:0]  pixRd,
	output wire                      pixREd,
	input  wire                      pixRe,
	// Frame regions
	input  wire  [pMemAdrsWidth-1:0] fbufAdrs1,
	input  wire  [pMemAdrsWidth-1:0] fbufAdrs2,
	input  wire  [pMemAdrsWidth-1:0] fbufLen1,
	input  wire  [pMemAdrsWidth-1:0] fbufLen2,
	input  wire                      dmaEn
);

	wire [pUfiBusWidth-1:0] fifoRd;
	wire                    fifoRVd;
	wire                    fifoRe;

	// RAM bus
	ufiBus #(.pDataWidth(pUfiBusWidth), .pAdrsWidth(pMemAdrsWidth)) ramBus ();

	// ------------------------------------------------------------
	// Pixel FIFO, engine and RAM
	// ------------------------------------------------------------
	dmaWriteFifo #(.pDepth(pFifoDepth), .pWidth(pUfiBusWidth)) writeFifo (
		.iClk(iClk), .rst(rst),
		.wd(pixWd), .we(pixWe), .full(pixFull),
		.rd(fifoRd), .re(fifoRe), .rVd(fifoRVd),
		.empty()                            // Engine uses the valid flag
	);

	videoDmaUnit #(.pUfiBusWidth(pUfiBusWidth), .pMemAdrsWidth(pMemAdrsWidth)) dmaUnit (
		.iClk(iClk), .rst(rst), .bus(ramBus.master),
		.fifoRd(fifoRd), .fifoRVd(fifoRVd), .fifoRe(fifoRe),
		.pixRd(pixRd), .pixREd(pixREd), .pixRe(pixRe),
		.fbufAdrs1(fbufAdrs1), .fbufAdrs2(fbufAdrs2),
		.fbufLen1(fbufLen1), .fbufLen2(fbufLen2), .dmaEn(dmaEn)
	);

	frameBufferRam #(
		.pDataWidth(pUfiBusWidth), .pAdrsWidth(pMemAdrsWidth), .pRefreshPeriod(cRefreshPeriod)
	) frameRam (
		.iClk(iClk), .rst(rst), .bus(ramBus.memory)
	);

endmodule

`default_nettype wire

/* hw/frameBufferRam.sv */
// Frame buffer RAM model
`default_nettype none

module frameBufferRam
	import videoDmaPkg::*;
#(
	parameter int pDataWidth     = cUfiBusWidth,
	parameter int pAdrsWidth     = cMemAdrsWidth,
	parameter int pRefreshPeriod = cRefreshPeriod
)(
	input  wire   iClk,
	input  wire   rst,
	ufiBus.memory bus
);

	localparam int refCntWidth = $clog2(pRefreshPeriod);

	logic [pDataWidth-1:0]  memArray [0:(1 << pAdrsWidth) - 1];
	logic [refCntWidth-1:0] refCnt;   // Refresh phase
	logic                   refLast;
	logic                   doWrite;
	logic                   doRead;

	// Request decode, strobe qualified by valid and command
	assign doWrite = bus.wEd & bus.vd & ~bus.cmd;
	assign doRead  = bus.rEd & bus.vd & bus.cmd;

	// ------------------------------------------------------------
	// Word array with registered read port
	// ------------------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (doWrite)
			memArray[bus.adrs] <= bus.wd;
		if (doRead)
			bus.rd <= memArray[bus.adrs];   // One cycle latency
	end

	always_ff @(posedge iClk)
	begin
		if (rst)
			bus.rdValid <= 1'b0;
		else
			bus.rdValid <= doRead;
	end

	// ------------------------------------------------------------
	// Refresh stalls
	// ------------------------------------------------------------
	assign refLast = (refCnt == refCntWidth'(pRefreshPeriod - 1));

	always_ff @(posedge iClk)
	begin
		if (rst)
		begin
			refCnt  <= '0;
			bus.rdy <= 1'b0;                // High on the first cycle out of reset
		end
		else
		begin
			if (refLast)
				refCnt <= '0;
			else
				refCnt <= refCnt + 1'b1;
			bus.rdy <= ~refLast;          // One cycle low per period
		end
	end

endmodule

`default_nettype wire

/* hw/videoDmaUnit.sv */
// Video frame buffer DMA engine
`default_nettype none

module videoDmaUnit
	import videoDmaPkg::*;
#(
	parameter int pUfiBusWidth  = cUfiBusWidth,
	parameter int pMemAdrsWidth = cMemAdrsWidth
)(
	input  wire                      iClk,
	input  wire                      rst,
	ufiBus.master                    bus,
	// Write FIFO side
	input  wire  [pUfiBusWidth-1:0]  fifoRd,
	input  wire                      fifoRVd,
	output logic                     fifoRe,
	// Pixel sink side
	output logic [pUfiBusWidth-1:0]  pixRd,
	output logic                     pixREd,
	input  wire                      pixRe,
	// Frame configuration
	input  wire  [pMemAdrsWidth-1:0] fbufAdrs1,
	input  wire  [pMemAdrsWidth-1:0] fbufAdrs2,
	input  wire  [pMemAdrsWidth-1:0] fbufLen1,
	input  wire  [pMemAdrsWidth-1:0] fbufLen2,
	input  wire                      dmaEn
);

	logic                     adrsSel;     // Low writes region 1, reads region 2
	logic [pMemAdrsWidth-1:0] wAdrs;
	logic [pMemAdrsWidth-1:0] rAdrs;
	logic [pMemAdrsWidth-1:0] region1End;
	logic [pMemAdrsWidth-1:0] region2End;
	logic                     wEnd;
	logic                     rEnd;
	logic                     swapNow;
	logic [cYieldWidth-1:0]   yieldCnt;
	logic                     yieldNow;
	logic                     rdGo;
	logic                     wrGo;

	// ------------------------------------------------------------
	// Region ends and swap condition
	// ------------------------------------------------------------
	assign region1End = fbufAdrs1 + fbufLen1;
	assign region2End = fbufAdrs2 + fbufLen2;

	// Writer and reader always sit in opposite regions
	assign wEnd = adrsSel ? (wAdrs == region2End) : (wAdrs == region1End);
	assign rEnd = adrsSel ? (rAdrs == region1End) : (rAdrs == region2End);

	assign swapNow = dmaEn & wEnd & rEnd;   // Both done with their frame

	// ------------------------------------------------------------
	// Bus yield counter
	// ------------------------------------------------------------
	// Counts ready cycles, last count value is the yield cycle
	assign yieldNow = (yieldCnt == {cYieldWidth{1'b1}});

	always_ff @(posedge iClk)
	begin
		if (rst || !dmaEn)
			yieldCnt <= '0;
		else if (yieldNow)
			yieldCnt <= '0;              // One cycle off the bus
		else if (bus.rdy)
			yieldCnt <= yieldCnt + 1'b1;
	end

	// ------------------------------------------------------------
	// Request selection
	// ------------------------------------------------------------
	// Sink demand wins the slot
	assign rdGo = dmaEn & pixRe & bus.rdy & ~yieldNow & ~rEnd;

	// Writer fills the slot when no read was taken
	assign wrGo = dmaEn & fifoRVd & bus.rdy & ~yieldNow & ~wEnd & ~rdGo;

	assign fifoRe = wrGo;   // Head word leaves with the registered write

	// ------------------------------------------------------------
	// Region select and address counters
	// ------------------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (rst || !dmaEn)
		begin
			adrsSel <= 1'b0;
			wAdrs   <= fbufAdrs1;
			rAdrs   <= fbufAdrs2;
		end
		else if (swapNow)
		begin
			adrsSel <= ~adrsSel;
			// Reload both from the new roles
			wAdrs   <= adrsSel ? fbufAdrs1 : fbufAdrs2;
			rAdrs   <= adrsSel ? fbufAdrs2 : fbufAdrs1;
		end
		else
		begin
			if (wrGo)
				wAdrs <= wAdrs + 1'b1;
			if (rdGo)
				rAdrs <= rAdrs + 1'b1;
		end
	end

	// ------------------------------------------------------------
	// Registered bus request
	// ------------------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (rst)
		begin
			bus.wEd <= 1'b0;
			bus.rEd <= 1'b0;
			bus.vd  <= 1'b0;
			bus.cmd <= 1'b0;
		end
		else
		begin
			bus.wEd <= wrGo;
			bus.rEd <= rdGo;
			bus.vd  <= rdGo | wrGo;
			bus.cmd <= rdGo;             // Read command
		end
	end

	// Address and data follow the chosen request
	always_ff @(posedge iClk)
	begin
		if (rdGo)
			bus.adrs <= rAdrs;
		else if (wrGo)
			bus.adrs <= wAdrs;
		if (wrGo)
			bus.wd <= fifoRd;            // Popped head word
	end

	// ------------------------------------------------------------
	// Returning read data toward the sink
	// ------------------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (bus.rdValid)
			pixRd <= bus.rd;
	end

	always_ff @(posedge iClk)
	begin
		if (rst)
			pixREd <= 1'b0;
		else
			pixREd <= bus.rdValid;       // Two cycles after rEd
	end

endmodule

`default_nettype wire

/* hw/dmaWriteFifo.sv */
// Show-ahead pixel write FIFO
`default_nettype none

module dmaWriteFifo
	import videoDmaPkg::*;
#(
	parameter int pDepth = cFifoDepth,
	parameter int pWidth = cUfiBusWidth
)(
	input  wire               iClk,
	input  wire               rst,
	input  wire  [pWidth-1:0] wd,     // Pixel from the source
	input  wire               we,
	output logic              full,
	output logic [pWidth-1:0] rd,     // Head word, always visible
	input  wire               re,     // Pops the head this cycle
	output logic              rVd,
	output logic              empty
);

	localparam int ptrWidth = $clog2(pDepth);
	localparam int cntWidth = $clog2(pDepth + 1);

	logic [pWidth-1:0]   fifoMem [0:pDepth-1];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [cntWidth-1:0] count;        // Words held
	logic                doPush;
	logic                doPop;

	// Pointer advance with wrap for any depth
	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		if (ptr == ptrWidth'(pDepth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign doPush = we & ~full;    // Write into a full FIFO is dropped
	assign doPop  = re & ~empty;

	// ------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (doPush)
			fifoMem[wrPtr] <= wd;
	end

	assign rd = fifoMem[rdPtr];   // Show-ahead head

	// ------------------------------------------------------------
	// Pointers and occupancy
	// ------------------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;      // Idle or push with pop
			endcase
		end
	end

	assign full  = (count == cntWidth'(pDepth));  // Rises the cycle after the last push
	assign empty = (count == '0);
	assign rVd   = ~empty;

endmodule

`default_nettype wire

/* hw/ufiBusIf.sv */
// RAM bus between DMA engine and memory
`default_nettype none

interface ufiBus #(
	parameter int pDataWidth = 16,
	parameter int pAdrsWidth = 10
);

	// Request side, driven by the engine
	logic [pDataWidth-1:0] wd;       // Write data
	logic [pAdrsWidth-1:0] adrs;     // Word address
	logic                  wEd;      // Write strobe
	logic                  rEd;      // Read strobe
	logic                  vd;       // Request valid
	logic                  cmd;      // High read, low write

	// Response side, driven by the RAM
	logic [pDataWidth-1:0] rd;       // Read data
	logic                  rdValid;  // Read data valid
	logic                  rdy;      // Ready level

	modport master (
		output wd, adrs, wEd, rEd, vd, cmd,
		input  rd, rdValid, rdy
	);

	modport memory (
		input  wd, adrs, wEd, rEd, vd, cmd,
		output rd, rdValid, rdy
	);

endinterface

`default_nettype wire

/* hw/videoDmaPkg.sv */
// Video DMA shared defaults
`default_nettype none

package videoDmaPkg;

	// ------------------------------------------------------------
	// Bus and memory sizing
	// ------------------------------------------------------------
	localparam int cUfiBusWidth  = 16;  // Pixel word and RAM data bus
	localparam int cMemAdrsWidth = 10;  // Word address, 1024 words in sim

	// ------------------------------------------------------------
	// Buffering
	// ------------------------------------------------------------
	localparam int cFifoDepth = 32;     // Write side pixel FIFO

	// ------------------------------------------------------------
	// Bus sharing and RAM behaviour
	// ------------------------------------------------------------
	// Engine gives the bus away for one cycle per full count
	localparam int cYieldWidth = 2;

	// RAM ready drops once in this many cycles
	localparam int cRefreshPeriod = 13;

endpackage

`default_nettype wire
